//--- sources.f
+incdir+verilog
verilog/uart_pkg.sv
verilog/uart_stream_if.sv
verilog/uart_des.sv
verilog/uart_ser.sv
verilog/uart_regs.sv
verilog/uart_top.sv
test/uart_tb.sv

//--- Bender.yml
package:
  name: uart_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/uart_pkg.sv
      - verilog/uart_stream_if.sv
      - verilog/uart_des.sv
      - verilog/uart_ser.sv
      - verilog/uart_regs.sv
      - verilog/uart_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/uart_tb.sv

//--- test/uart_tb.sv
// testbench of the UART controller
// rxd comes from txd in loopback, or from a line driven here for bad frames
// the watchdog is sized for table bit periods up to bdr_max
`default_nettype none

`include "uart_defines.svh"

module uart_tb import uart_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int rows    = 6;
  localparam int bdr_max = 15;

  logic      bus;
  logic      rst;
  logic      reg_vld;
  logic      reg_wen;
  uart_adr_t reg_adr;
  uart_reg_t reg_wdt;
  logic      reg_rdy;
  uart_reg_t reg_rdt;
  logic      rxd;
  logic      txd;
  logic      loop_sel;
  logic      line;
  integer    seed;

  // byte, bit period minus 1, sample position, stop bit sent low
  typedef struct packed {
    uart_dat_t byt;
    uart_cnt_t bdr;
    uart_cnt_t smp;
    logic      fer;
  } row_t;

  row_t tbl [rows] = '{
    '{8'h55, 16'd3,  16'd1, 1'b0},
    '{8'ha3, 16'd7,  16'd3, 1'b0},
    '{8'h00, 16'd4,  16'd2, 1'b0},
    '{8'hff, 16'd9,  16'd8, 1'b0},
    '{8'h3c, 16'd5,  16'd2, 1'b1},
    '{8'h81, 16'd15, 16'd7, 1'b1}
  };

  assign rxd = loop_sel ? txd : line;

  uart_top uart_top_i (
    .bus     (bus),
    .rst     (rst),
    .reg_vld (reg_vld),
    .reg_wen (reg_wen),
    .reg_adr (reg_adr),
    .reg_wdt (reg_wdt),
    .reg_rdy (reg_rdy),
    .reg_rdt (reg_rdt),
    .rxd     (rxd),
    .txd     (txd)
  );

  initial begin
    bus = 1'b0;
    forever #5 bus = ~bus;
  end

  //////////////////////////////
  // reporting
  //////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  //////////////////////////////
  // register bus
  //////////////////////////////

  // one transfer with read data and ready sampled at mid cycle
  task automatic bus_access(input logic wen, input int adr, input uart_reg_t wdt,
                            output uart_reg_t rdt, output int stall);
    stall = 0;
    @(posedge bus);
    reg_vld <= 1'b1;
    reg_wen <= wen;
    reg_adr <= uart_adr_t'(adr);
    reg_wdt <= wdt;
    @(negedge bus);
    while (!reg_rdy) begin
      stall++;
      @(negedge bus);
    end
    rdt = reg_rdt;
    // transfer happens on this edge
    @(posedge bus);
    reg_vld <= 1'b0;
    reg_wen <= 1'b0;
  endtask

  task automatic bus_write(input int adr, input uart_reg_t wdt);
    uart_reg_t rdt;
    int        stall;
    bus_access(1'b1, adr, wdt, rdt, stall);
  endtask

  task automatic bus_read(input int adr, output uart_reg_t rdt);
    int stall;
    bus_access(1'b0, adr, '0, rdt, stall);
  endtask

  // polls STS for a few frames at this bit period
  task automatic wait_sts(input uart_reg_t mask, input uart_reg_t want, input int bdr);
    uart_reg_t sts;
    int        polls;
    polls = 0;
    bus_read(`UART_ADR_STS, sts);
    while ((sts & mask) != want) begin
      polls++;
      if (polls > 24 * (bdr + 1)) abort_run("status poll gave up, flag never reached its value");
      bus_read(`UART_ADR_STS, sts);
    end
  endtask

  //////////////////////////////
  // serial helpers
  //////////////////////////////

  // start, data LSB first, stop, then one idle period
  task automatic send_line(input uart_dat_t byt, input logic stop, input int bdr);
    logic [9:0] frm;
    frm = {stop, byt, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge bus);
      line <= frm[i];
      repeat (bdr) @(posedge bus);
    end
    @(posedge bus);
    line <= 1'b1;
    repeat (bdr) @(posedge bus);
  endtask

  task automatic loop_byte(input uart_dat_t byt, input int bdr);
    uart_reg_t rdt;
    bus_write(`UART_ADR_TXD, uart_reg_t'(byt));
    // start bit one cycle after the write
    @(negedge bus);
    check("txd", txd, 1'b0);
    wait_sts(16'h1, 16'h1, bdr);
    // a good stop bit leaves no frame error on the held byte
    bus_read(`UART_ADR_STS, rdt);
    check("sts frame error", rdt & 16'h4, 16'h0);
    bus_read(`UART_ADR_RXD, rdt);
    check("rxd data", rdt, byt);
    bus_read(`UART_ADR_STS, rdt);
    check("sts full and frame error", rdt & 16'h5, 16'h0);
    // transmitter idle before timing changes
    wait_sts(16'h8, 16'h0, bdr);
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    uart_reg_t rdt;
    int        stall;
    int        bdr;
    uart_dat_t b1;
    uart_dat_t b2;
    seed     = 66598;
    rst      = 1'b1;
    reg_vld  = 1'b0;
    reg_wen  = 1'b0;
    reg_adr  = '0;
    reg_wdt  = '0;
    loop_sel = 1'b1;
    line     = 1'b1;
    repeat (8) @(posedge bus);
    rst <= 1'b0;

    // reset values and read back
    bus_read(`UART_ADR_STS, rdt);
    check("sts", rdt, 16'h0);
    bus_read(`UART_ADR_BDR, rdt);
    check("bdr", rdt, 16'h0);
    bus_read(`UART_ADR_SMP, rdt);
    check("smp", rdt, 16'h0);
    check("txd", txd, 1'b1);
    bus_write(`UART_ADR_BDR, 16'hbeef);
    bus_write(`UART_ADR_SMP, 16'h1234);
    bus_read(`UART_ADR_BDR, rdt);
    check("bdr", rdt, 16'hbeef);
    bus_read(`UART_ADR_SMP, rdt);
    check("smp", rdt, 16'h1234);

    // table rows through loopback or with a bad stop bit on the line
    for (int i = 0; i < rows; i++) begin
      bdr = tbl[i].bdr;
      bus_write(`UART_ADR_BDR, uart_reg_t'(tbl[i].bdr));
      bus_write(`UART_ADR_SMP, uart_reg_t'(tbl[i].smp));
      if (!tbl[i].fer) begin
        loop_byte(tbl[i].byt, bdr);
        loop_byte(uart_dat_t'($random(seed)), bdr);
      end else begin
        @(posedge bus);
        loop_sel <= 1'b0;
        send_line(tbl[i].byt, 1'b0, bdr);
        wait_sts(16'h1, 16'h1, bdr);
        bus_read(`UART_ADR_STS, rdt);
        check("sts frame error", rdt & 16'h4, 16'h4);
        bus_read(`UART_ADR_RXD, rdt);
        check("rxd data", rdt, tbl[i].byt);
        bus_read(`UART_ADR_STS, rdt);
        check("sts flags", rdt & 16'h7, 16'h0);
        @(posedge bus);
        loop_sel <= 1'b1;
      end
    end

    // back-pressure at the first row's timing
    bdr = tbl[0].bdr;
    bus_write(`UART_ADR_BDR, uart_reg_t'(tbl[0].bdr));
    bus_write(`UART_ADR_SMP, uart_reg_t'(tbl[0].smp));
    b1 = uart_dat_t'($random(seed));
    b2 = uart_dat_t'($random(seed));
    bus_write(`UART_ADR_TXD, uart_reg_t'(b1));
    // offered one cycle after the first and held until the frame ends
    bus_access(1'b1, `UART_ADR_TXD, uart_reg_t'(b2), rdt, stall);
    check("txd write stall cycles", stall, 10 * (bdr + 1) - 1);
    wait_sts(16'h1, 16'h1, bdr);
    bus_read(`UART_ADR_RXD, rdt);
    check("rxd first byte", rdt, b1);
    wait_sts(16'h1, 16'h1, bdr);
    bus_read(`UART_ADR_RXD, rdt);
    check("rxd second byte", rdt, b2);
    wait_sts(16'h8, 16'h0, bdr);

    // overrun from two bytes with no read between them
    b1 = uart_dat_t'($random(seed));
    b2 = uart_dat_t'($random(seed));
    bus_write(`UART_ADR_TXD, uart_reg_t'(b1));
    bus_write(`UART_ADR_TXD, uart_reg_t'(b2));
    wait_sts(16'h2, 16'h2, bdr);
    bus_read(`UART_ADR_STS, rdt);
    check("sts full and overrun", rdt & 16'h7, 16'h3);
    bus_read(`UART_ADR_RXD, rdt);
    check("rxd held byte", rdt, b1);
    bus_write(`UART_ADR_STS, 16'h2);
    bus_read(`UART_ADR_STS, rdt);
    check("sts overrun", rdt & 16'h7, 16'h0);
    wait_sts(16'h8, 16'h0, bdr);

    $display("Simulation passed");
    $finish;
  end

  // a dozen frames per table row at the slowest bit period plus margin
  initial begin
    #(rows * 12 * (bdr_max + 1) * 10 * 10 + 5000);
    abort_run("watchdog expired, the run did not finish in time");
  end

endmodule : uart_tb

`default_nettype wire

//--- verilog/uart_top.sv
// UART controller top level, register bus plus rxd and txd pins
// rxd is expected idle high, it sees a single delay flop only
// register map and widths are in the defines header
`default_nettype none

module uart_top import uart_pkg::*; (
  input  wire logic      bus,
  input  wire logic      rst,
  // register bus
  input  wire logic      reg_vld,
  input  wire logic      reg_wen,
  input  wire uart_adr_t reg_adr,
  input  wire uart_reg_t reg_wdt,
  output wire logic      reg_rdy,
  output uart_reg_t      reg_rdt,
  // serial pins
  input  wire logic      rxd,
  output wire logic      txd
);

  uart_cnt_t cfg_bdr;
  uart_cnt_t cfg_smp;

  // byte streams, engines on one side and registers on the other
  uart_stream_if rx ();
  uart_stream_if tx ();

  uart_regs uart_regs_i (
    .bus     (bus),
    .rst     (rst),
    .reg_vld (reg_vld),
    .reg_wen (reg_wen),
    .reg_adr (reg_adr),
    .reg_wdt (reg_wdt),
    .reg_rdy (reg_rdy),
    .reg_rdt (reg_rdt),
    .cfg_bdr (cfg_bdr),
    .cfg_smp (cfg_smp),
    .rx      (rx.snk),
    .tx      (tx.src)
  );

  // receiver
  uart_des uart_des_i (
    .bus     (bus),
    .rst     (rst),
    .cfg_bdr (cfg_bdr),
    .cfg_smp (cfg_smp),
    .rxd     (rxd),
    .rx      (rx.src)
  );

  // transmitter, sample position not needed
  uart_ser uart_ser_i (
    .bus     (bus),
    .rst     (rst),
    .cfg_bdr (cfg_bdr),
    .tx      (tx.snk),
    .txd     (txd)
  );

endmodule : uart_top

`default_nettype wire

//--- verilog/uart_regs.sv
// register block of the UART controller
// one byte receive holding register, overrun when a byte arrives while full
// a TXD write waits on reg_rdy until the transmitter is idle
// reads and writes of unmapped addresses are ignored and read as zero
`default_nettype none

`include "uart_defines.svh"

module uart_regs import uart_pkg::*; (
  input  wire logic      bus,
  input  wire logic      rst,
  input  wire logic      reg_vld,
  input  wire logic      reg_wen,
  input  wire uart_adr_t reg_adr,
  input  wire uart_reg_t reg_wdt,
  output wire logic      reg_rdy,
  output uart_reg_t      reg_rdt,
  output uart_cnt_t      cfg_bdr,
  output uart_cnt_t      cfg_smp,
  uart_stream_if.snk     rx,
  uart_stream_if.src     tx
);

  logic      reg_trn;
  logic      txd_wen;
  logic      rxd_ren;
  logic      sts_wen;
  logic      rx_trn;
  uart_dat_t rx_dat;
  logic      rx_full;
  logic      rx_ovr;
  logic      rx_fer;

  //////////////////////////////
  // bus decode
  //////////////////////////////

  // TXD write is offered to the transmitter before it completes
  assign txd_wen = reg_vld & reg_wen & (reg_adr == uart_adr_t'(`UART_ADR_TXD));
  // back-pressure only on TXD writes
  assign reg_rdy = ~txd_wen | tx.rdy;
  assign reg_trn = reg_vld & reg_rdy;

  assign rxd_ren = reg_trn & ~reg_wen & (reg_adr == uart_adr_t'(`UART_ADR_RXD));
  assign sts_wen = reg_trn & reg_wen & (reg_adr == uart_adr_t'(`UART_ADR_STS));

  // configuration
  always_ff @(posedge bus, posedge rst) begin
    if (rst) begin
      cfg_bdr <= '0;
      cfg_smp <= '0;
    end else if (reg_trn && reg_wen) begin
      if (reg_adr == uart_adr_t'(`UART_ADR_BDR)) cfg_bdr <= uart_cnt_t'(reg_wdt);
      if (reg_adr == uart_adr_t'(`UART_ADR_SMP)) cfg_smp <= uart_cnt_t'(reg_wdt);
    end
  end

  //////////////////////////////
  // transmit side
  //////////////////////////////

  assign tx.vld = txd_wen;
  assign tx.dat = uart_dat_t'(reg_wdt);
  assign tx.err = 1'b0;

  //////////////////////////////
  // receive side
  //////////////////////////////

  assign rx.rdy = ~rx_full;
  assign rx_trn = rx.vld & rx.rdy;

  // held byte, written only when empty
  always_ff @(posedge bus) begin
    if (rx_trn) rx_dat <= rx.dat;
  end

  // new byte wins over a same cycle read
  always_ff @(posedge bus, posedge rst) begin
    if (rst) begin
      rx_full <= 1'b0;
      rx_fer  <= 1'b0;
      rx_ovr  <= 1'b0;
    end else begin
      if (rxd_ren) begin
        rx_full <= 1'b0;
        rx_fer  <= 1'b0;
      end
      if (rx_trn) begin
        rx_full <= 1'b1;
        rx_fer  <= rx.err;
      end
      // sticky, cleared by writing a one to bit 1
      if (sts_wen && reg_wdt[1]) rx_ovr <= 1'b0;
      if (rx.vld && rx_full) rx_ovr <= 1'b1;
    end
  end

  //////////////////////////////
  // read data
  //////////////////////////////

  always_comb begin
    case (reg_adr)
      uart_adr_t'(`UART_ADR_BDR): reg_rdt = uart_reg_t'(cfg_bdr);
      uart_adr_t'(`UART_ADR_SMP): reg_rdt = uart_reg_t'(cfg_smp);
      uart_adr_t'(`UART_ADR_RXD): reg_rdt = uart_reg_t'(rx_dat);
      // tx busy, frame error, overrun, full
      uart_adr_t'(`UART_ADR_STS): reg_rdt = uart_reg_t'({~tx.rdy, rx_fer, rx_ovr, rx_full});
      default:                    reg_rdt = '0;
    endcase
  end

  // transmitter only sees requests from a bus cycle
  tx_from_bus: assert property (@(posedge bus) disable iff (rst)
    tx.vld |-> reg_vld && reg_wen);

endmodule : uart_regs

`default_nettype wire

//--- verilog/uart_ser.sv
// serial transmitter, 8N1 frames, LSB first
// each bit lasts cfg_bdr+1 clocks, cfg_bdr must stay fixed during a frame
// accepts a byte only while idle, rdy rises after the stop bit
`default_nettype none

`include "uart_defines.svh"

module uart_ser import uart_pkg::*; (
  input  wire logic      bus,
  input  wire logic      rst,
  input  wire uart_cnt_t cfg_bdr,
  uart_stream_if.snk     tx,
  output wire logic      txd
);

  // start, data and stop bits
  localparam int unsigned frm_w = `UART_DW + 2;
  localparam int unsigned cnt_w = $clog2(frm_w);

  logic             tx_trn;
  logic             busy;
  uart_cnt_t        bdr_cnt;
  logic             bdr_end;
  logic [cnt_w-1:0] bit_cnt;
  logic [frm_w-1:0] shf_frm;

  assign tx.rdy  = ~busy;
  assign tx_trn  = tx.vld & tx.rdy;
  assign bdr_end = bdr_cnt == cfg_bdr;

  //////////////////////////////
  // frame shifter
  //////////////////////////////

  always_ff @(posedge bus, posedge rst) begin
    if (rst) begin
      busy    <= 1'b0;
      bdr_cnt <= '0;
      bit_cnt <= '0;
      // all ones keeps the line idle high
      shf_frm <= '1;
    end else if (tx_trn) begin
      busy    <= 1'b1;
      bdr_cnt <= '0;
      bit_cnt <= '0;
      shf_frm <= {1'b1, tx.dat, 1'b0};
    end else if (busy) begin
      if (bdr_end) begin
        bdr_cnt <= '0;
        // ones fill in behind the stop bit
        shf_frm <= {1'b1, shf_frm[frm_w-1:1]};
        if (bit_cnt == cnt_w'(frm_w - 1)) begin
          busy <= 1'b0;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else begin
        bdr_cnt <= bdr_cnt + 1'b1;
      end
    end
  end

  // straight from a flop, no glitches on the line
  assign txd = shf_frm[0];

  // idle line is always high
  txd_idle: assert property (@(posedge bus) disable iff (rst)
    tx.rdy |-> txd);

endmodule : uart_ser

`default_nettype wire

//--- verilog/uart_des.sv
// asynchronous serial receiver, 8N1 frames, LSB first
// rxd passes one delay flop only, metastability is left to the user
// cfg_smp must not exceed cfg_bdr, otherwise bits are never sampled
// never stalls, vld pulses one cycle whatever rdy says
`default_nettype none

`include "uart_defines.svh"

module uart_des import uart_pkg::*; (
  input  wire logic      bus,
  input  wire logic      rst,
  input  wire uart_cnt_t cfg_bdr,
  input  wire uart_cnt_t cfg_smp,
  input  wire logic      rxd,
  uart_stream_if.src     rx
);

  localparam int unsigned bit_w = $clog2(`UART_DW);

  uart_rx_state_t   state;
  uart_cnt_t        bdr_cnt;
  logic             bdr_end;
  logic             bdr_smp;
  logic [bit_w-1:0] bit_cnt;
  logic             rxd_dly;
  logic             rxd_edg;
  uart_dat_t        shf_dat;
  logic             rx_vld;
  logic             rx_err;

  //////////////////////////////
  // start edge
  //////////////////////////////

  always_ff @(posedge bus, posedge rst) begin
    if (rst) begin
      rxd_dly <= 1'b1;
    end else begin
      rxd_dly <= rxd;
    end
  end

  // high to low on the line
  assign rxd_edg = rxd_dly & ~rxd;

  //////////////////////////////
  // bit timing
  //////////////////////////////

  assign bdr_end = bdr_cnt == cfg_bdr;
  assign bdr_smp = bdr_cnt == cfg_smp;

  // restarts every bit period, held at zero while idle
  always_ff @(posedge bus, posedge rst) begin
    if (rst) begin
      bdr_cnt <= '0;
    end else if (state == rx_idle || bdr_end) begin
      bdr_cnt <= '0;
    end else begin
      bdr_cnt <= bdr_cnt + 1'b1;
    end
  end

  //////////////////////////////
  // frame FSM
  //////////////////////////////

  always_ff @(posedge bus, posedge rst) begin
    if (rst) begin
      state   <= rx_idle;
      bit_cnt <= '0;
      rx_vld  <= 1'b0;
    end else begin
      rx_vld <= 1'b0;
      case (state)
        rx_idle: begin
          if (rxd_edg) state <= rx_start;
        end
        rx_start: begin
          // glitch, line back high at the sample point
          if (bdr_smp && rxd_dly) begin
            state <= rx_idle;
          end else if (bdr_end) begin
            state   <= rx_data;
            bit_cnt <= '0;
          end
        end
        rx_data: begin
          if (bdr_end) begin
            if (bit_cnt == bit_w'(`UART_DW - 1)) state <= rx_stop;
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default: begin
          // stop bit, byte is handed over one cycle after its sample
          if (bdr_smp) begin
            state  <= rx_idle;
            rx_vld <= 1'b1;
          end
        end
      endcase
    end
  end

  // data shifter and stop check
  always_ff @(posedge bus) begin
    if (state == rx_data && bdr_smp) shf_dat <= {rxd_dly, shf_dat[`UART_DW-1:1]};
    if (state == rx_stop && bdr_smp) rx_err <= ~rxd_dly;
  end

  assign rx.vld = rx_vld;
  assign rx.dat = shf_dat;
  assign rx.err = rx_err;

  // sample point has to fall inside the bit period
  smp_in_bit: assert property (@(posedge bus) disable iff (rst)
    state != rx_idle |-> cfg_smp <= cfg_bdr);
  // last data bit was shifted in a full period before vld
  dat_stable: assert property (@(posedge bus) disable iff (rst)
    rx.vld |-> $stable(rx.dat));

endmodule : uart_des

`default_nettype wire

//--- verilog/uart_stream_if.sv
// byte stream between the serial engines and the register block
// a byte moves in a cycle with vld and rdy both high
// err is only meaningful together with vld
`default_nettype none

interface uart_stream_if import uart_pkg::*; ();

  logic      vld;
  logic      rdy;
  uart_dat_t dat;
  // frame error, stop bit seen low
  logic      err;

  // producer side
  modport src (output vld, output dat, output err, input rdy);
  // consumer side
  modport snk (input vld, input dat, input err, output rdy);

endinterface : uart_stream_if

`default_nettype wire

//--- verilog/uart_pkg.sv
// common types of the UART controller
// widths come from the defines header
`default_nettype none

`include "uart_defines.svh"

package uart_pkg;

  // one data byte on the serial line
  typedef logic [`UART_DW-1:0] uart_dat_t;
  // baud counter, bit period and sample position
  typedef logic [`UART_CW-1:0] uart_cnt_t;
  // register bus address and data word
  typedef logic [`UART_AW-1:0] uart_adr_t;
  typedef logic [`UART_BW-1:0] uart_reg_t;

  // receiver frame states
  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } uart_rx_state_t;

endpackage : uart_pkg

`default_nettype wire

//--- verilog/uart_defines.svh
// shared widths and register map of the UART controller
// all sizes are fixed here, modules take no parameter overrides
// register data must be at least as wide as the baud counter
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// data bits per frame, 8N1 framing around them
`define UART_DW 8
// baud counter and configuration width
`define UART_CW 16
// register bus address and data widths
`define UART_AW 3
`define UART_BW 16

// register addresses, cast to the address type at use
`define UART_ADR_BDR 0
`define UART_ADR_SMP 1
`define UART_ADR_TXD 2
`define UART_ADR_RXD 3
`define UART_ADR_STS 4

`endif
